// ==== build.f ====
+incdir+verilog
+incdir+verification
verilog/isa_pkg.sv
verilog/decode_pkg.sv
verilog/ins_group_former.sv
verilog/ins_group_queue.sv
verilog/fp_cvt32to64.sv
verilog/decode_imm.sv
verilog/imm_decode_top.sv
verification/imm_decode_tb.sv

// ==== Bender.yml ====
package:
  name: imm_decode

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/isa_pkg.sv
      - verilog/decode_pkg.sv
      - verilog/ins_group_former.sv
      - verilog/ins_group_queue.sv
      - verilog/fp_cvt32to64.sv
      - verilog/decode_imm.sv
      - verilog/imm_decode_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/imm_decode_tb.sv

// ==== verification/imm_decode_model.svh ====
// Reference model for the immediate decode front end
// Rebuilds the expected immediates of a group from the extension rules,
// the postfix ordering rule and the single to double conversion rule

`ifndef IMM_DECODE_MODEL_SVH
`define IMM_DECODE_MODEL_SVH

// Single to double by exponent arithmetic, denormals flush to signed zero
function automatic logic [63:0] single_to_double(input logic [31:0] s);
	logic [63:0] d;
	int          e;
	e = s[30:23];
	d = '0;
	d[63] = s[31];
	if (e == 255)
	begin
		d[62:52] = 11'h7ff;
		d[51:29] = s[22:0];
	end
	else if (e != 0)
	begin
		d[62:52] = 11'(e - 127 + 1023);
		d[51:29] = s[22:0];
	end
	return d;
endfunction

// Fills every bit above a field of the given width
// Mode 0 copies the field's top bit, mode 1 fills zeros, mode 2 fills ones
function automatic logic [63:0] widen_field(input logic [63:0] v, input int width,
	input int mode);
	logic [63:0] r;
	logic        fill;
	r = v;
	fill = (mode == 0) ? v[width-1] : (mode == 2);
	for (int i = width; i < 64; i++)
		r[i] = fill;
	return r;
endfunction

// Expected decoder result for one group
function automatic imm_out_t model_decode(input ins_group_t g);
	imm_out_t    r;
	logic [39:0] w;
	logic [63:0] imm [3];
	logic        has [3];
	logic        dbl;
	opcode_e     kind;
	int          ix;
	w = g[0];
	for (int k = 0; k < 3; k++)
	begin
		imm[k] = '0;
		has[k] = 1'b0;
	end
	case (g[0].any.opcode)
	OP_ADDI, OP_LDO, OP_STO:
	begin
		imm[1] = widen_field(64'(w[39:19]), 21, 0);
		has[1] = 1'b1;
	end
	OP_ANDI:
	begin
		imm[1] = widen_field(64'(w[39:19]), 21, 2);
		has[1] = 1'b1;
	end
	OP_ORI:
	begin
		imm[1] = widen_field(64'(w[31:19]), 13, 1);
		has[1] = 1'b1;
	end
	OP_BCC:
	begin
		imm[2] = widen_field(64'({w[39:25], w[12:11]}), 17, 0);
		has[2] = 1'b1;
	end
	default:
	begin
	end
	endcase
	dbl = (g[0].any.opcode == OP_FLT3) && (w[26:25] == 2'd2);
	// Skip one vector qualifier, then walk A, B and C in order
	ix = (g[1].any.opcode == OP_VEC) ? 2 : 1;
	for (int k = 0; k < 3; k++)
	begin
		kind = (k == 0) ? OP_PFXA32 : ((k == 1) ? OP_PFXB32 : OP_PFXC32);
		if (ix < `DEC_GROUP_LEN)
		begin
			if (g[ix].any.opcode == kind)
			begin
				imm[k] = widen_field(64'(g[ix].pfx.val), 32, 0);
				if (dbl)
					imm[k] = single_to_double(g[ix].pfx.val);
				has[k] = 1'b1;
				ix++;
				// A second postfix of the same kind gives the upper half
				if (ix < `DEC_GROUP_LEN)
				begin
					if (g[ix].any.opcode == kind)
					begin
						imm[k][63:32] = g[ix].pfx.val;
						ix++;
					end
				end
			end
		end
	end
	r.imma     = imm[0];
	r.immb     = imm[1];
	r.immc     = imm[2];
	r.has_imma = has[0];
	r.has_immb = has[1];
	r.has_immc = has[2];
	return r;
endfunction

`endif

// ==== verification/imm_decode_tb.sv ====
// Testbench for the immediate decode front end
// Drives random groups through the credit link, holds the output in stalls,
// and checks every result and its order against the reference model

`timescale 1ns/10ps
`include "decode_params.svh"

module imm_decode_tb import isa_pkg::*, decode_pkg::*;
();

	localparam int GROUP_TOTAL    = 400;
	localparam int TIMEOUT_CYCLES = GROUP_TOTAL * 20;

	logic       clk;
	logic       arst_n;
	ins_group_t in_group;
	logic       in_valid;
	logic       in_ready;
	imm_out_t   out_imm;
	logic       out_valid;
	logic       out_ready;

	// Scoreboard state
	imm_out_t exp_q [$];
	int       stamp_q [$];
	int       cycle;
	int       accepted;
	int       received;
	int       mismatch_errors;
	int       other_errors;
	logic     check_latency;

	`include "imm_decode_model.svh"

	imm_decode_top i_imm_decode_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_group  (in_group),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_imm   (out_imm),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// ======================================================================
	// Stimulus generation
	// ======================================================================
	function automatic opcode_e opcode_at_index(input int idx);
		case (idx)
		0:       return OP_NOP;
		1:       return OP_ADDI;
		2:       return OP_ANDI;
		3:       return OP_ORI;
		4:       return OP_LDO;
		5:       return OP_STO;
		6:       return OP_BCC;
		7:       return OP_FLT3;
		8:       return OP_VEC;
		9:       return OP_PFXA32;
		10:      return OP_PFXB32;
		default: return OP_PFXC32;
		endcase
	endfunction

	// Postfix constant that often has a zero or all-ones single exponent
	function automatic logic [31:0] pfx_value();
		logic [31:0] v;
		v = $urandom;
		case ($urandom_range(3))
		0:       v[30:23] = 8'h00;
		1:       v[30:23] = 8'hff;
		default: v = v;
		endcase
		return v;
	endfunction

	function automatic ins_group_t make_group();
		ins_group_t g;
		int         pos;
		int         reps;
		// Filler words never look like a qualifier or a postfix
		for (int i = 0; i < `DEC_GROUP_LEN; i++)
		begin
			g[i] = {$urandom, 8'($urandom)};
			g[i].any.opcode = opcode_at_index($urandom_range(7));
		end
		g[0].any.opcode = opcode_at_index($urandom_range(11));
		if (g[0].any.opcode == OP_FLT3 && $urandom_range(1) == 1)
			g[0].any.imm21[7:6] = 2'd2;
		// Now and then the tail is arbitrary so postfixes come out of order
		if ($urandom_range(7) == 0)
		begin
			for (int i = 1; i < `DEC_GROUP_LEN; i++)
				g[i].any.opcode = opcode_at_index($urandom_range(11));
			return g;
		end
		pos = 1;
		if ($urandom_range(2) == 0)
		begin
			g[1].any.opcode = OP_VEC;
			pos = 2;
		end
		for (int k = 0; k < 3; k++)
		begin
			if ($urandom_range(3) != 0)
			begin
				reps = $urandom_range(2, 1);
				for (int r = 0; r < reps; r++)
				begin
					if (pos < `DEC_GROUP_LEN)
					begin
						g[pos].pfx.val = pfx_value();
						g[pos].pfx.opcode = opcode_at_index(9 + k);
						pos++;
					end
				end
			end
		end
		return g;
	endfunction

	// ======================================================================
	// Scoreboard
	// ======================================================================
	task automatic check_field(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			mismatch_errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_result(input imm_out_t got, input imm_out_t exp);
		check_field("out_imm.imma", got.imma, exp.imma);
		check_field("out_imm.immb", got.immb, exp.immb);
		check_field("out_imm.immc", got.immc, exp.immc);
		check_field("out_imm.has_imma", 64'(got.has_imma), 64'(exp.has_imma));
		check_field("out_imm.has_immb", 64'(got.has_immb), 64'(exp.has_immb));
		check_field("out_imm.has_immc", 64'(got.has_immc), 64'(exp.has_immc));
	endtask

	// Both handshakes are sampled on the rising edge before any register moves
	always @(posedge clk)
	begin : monitor
		imm_out_t exp_r;
		int       stamp;
		cycle++;
		if (arst_n && in_valid && in_ready)
		begin
			exp_q.push_back(model_decode(in_group));
			stamp_q.push_back(check_latency ? cycle : -1);
			accepted++;
		end
		if (arst_n && out_valid && out_ready)
		begin
			received++;
			if (exp_q.size() == 0)
			begin
				other_errors++;
				$display("result delivered with no accepted group outstanding");
			end
			else
			begin
				exp_r = exp_q.pop_front();
				stamp = stamp_q.pop_front();
				compare_result(out_imm, exp_r);
				if (stamp >= 0)
					check_field("latency", 64'(cycle - stamp), 64'd3);
			end
		end
	end

	initial
	begin : watchdog
		while (cycle < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("timeout after %0d cycles, the run did not complete", cycle);
		$display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
		$display("Some tests failed");
		$finish;
	end

	// ======================================================================
	// Traffic phases
	// ======================================================================
	task automatic run_traffic(input int n_groups, input int valid_pct,
		input int ready_pct);
		ins_group_t cur;
		int         sent;
		sent = 0;
		cur = make_group();
		while (sent < n_groups)
		begin
			@(negedge clk);
			in_group = cur;
			in_valid = $urandom_range(99) < valid_pct;
			out_ready = $urandom_range(99) < ready_pct;
			@(posedge clk);
			if (in_valid && in_ready)
			begin
				sent++;
				cur = make_group();
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic drain_results();
		@(negedge clk);
		in_valid = 1'b0;
		out_ready = 1'b1;
		while (exp_q.size() != 0)
			@(negedge clk);
		@(negedge clk);
	endtask

	// With the output held the output register and every queue entry fill up
	task automatic fill_and_recover();
		ins_group_t cur;
		int         taken;
		int         idle;
		taken = 0;
		idle = 0;
		cur = make_group();
		@(negedge clk);
		out_ready = 1'b0;
		in_valid = 1'b1;
		while (idle < 8)
		begin
			in_group = cur;
			@(posedge clk);
			if (in_ready)
			begin
				taken++;
				idle = 0;
				cur = make_group();
			end
			else
				idle++;
			@(negedge clk);
		end
		check_field("fill_count", 64'(taken), 64'(`DEC_QUEUE_DEPTH + 1));
		in_group = cur;
		out_ready = 1'b1;
		// Credits come back once the output drains, then the held group goes in
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	initial
	begin : main
		void'($urandom(32'h06c74dba));
		cycle = 0;
		accepted = 0;
		received = 0;
		mismatch_errors = 0;
		other_errors = 0;
		check_latency = 1'b0;
		in_group = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		arst_n = 1'b0;
		repeat (16)
		begin
			@(posedge clk);
			if (out_valid !== 1'b0)
			begin
				other_errors++;
				$display("out_valid was high while reset was asserted");
			end
		end
		@(negedge clk);
		arst_n = 1'b1;
		@(posedge clk);
		if (out_valid !== 1'b0)
		begin
			other_errors++;
			$display("out_valid was high in the first cycle after reset");
		end
		if (in_ready !== 1'b1)
		begin
			other_errors++;
			$display("in_ready did not rise in the first cycle after reset");
		end
		// Without stalls every result must take exactly three cycles
		@(negedge clk);
		check_latency = 1'b1;
		run_traffic(150, 60, 100);
		drain_results();
		check_latency = 1'b0;
		fill_and_recover();
		drain_results();
		run_traffic(GROUP_TOTAL - accepted, 70, 50);
		drain_results();
		check_field("result_count", 64'(received), 64'(accepted));
		$display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== verilog/imm_decode_top.sv ====
// Immediate decode front end
// Group former feeding the group queue over a credit link, with the
// immediate decoder draining the queue

`timescale 1ns/10ps

module imm_decode_top import decode_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  ins_group_t in_group,
	input  logic       in_valid,
	output logic       in_ready,
	output imm_out_t   out_imm,
	output logic       out_valid,
	input  logic       out_ready
);

	// Credit link between former and queue
	logic       push;
	ins_group_t push_group;
	logic       credit_return;

	// Queue head towards the decoder
	logic       pop_valid;
	ins_group_t pop_group;
	logic       pop;

	ins_group_former i_ins_group_former (
		.clk           (clk),
		.arst_n        (arst_n),
		.in_group      (in_group),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.push          (push),
		.push_group    (push_group),
		.credit_return (credit_return)
	);

	ins_group_queue i_ins_group_queue (
		.clk           (clk),
		.arst_n        (arst_n),
		.push          (push),
		.push_group    (push_group),
		.pop_valid     (pop_valid),
		.pop_group     (pop_group),
		.pop           (pop),
		.credit_return (credit_return)
	);

	decode_imm i_decode_imm (
		.clk       (clk),
		.arst_n    (arst_n),
		.pop_valid (pop_valid),
		.pop_group (pop_group),
		.pop       (pop),
		.out_imm   (out_imm),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

// ==== verilog/decode_imm.sv ====
// Immediate decoder
// Extracts up to three 64-bit immediates for the leading instruction of a
// group, from its own fields and from in-order 32-bit postfix words

`timescale 1ns/10ps
`include "decode_params.svh"

module decode_imm import isa_pkg::*, decode_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       pop_valid,
	input  ins_group_t pop_group,
	output logic       pop,
	output imm_out_t   out_imm,
	output logic       out_valid,
	input  logic       out_ready
);

	logic [39:0] w0;
	logic        fp_dbl;
	logic        pfx_lo [3];
	logic        pfx_hi [3];
	logic [2:0]  lo_ndx [3];
	logic [2:0]  hi_ndx [3];
	logic [31:0] cvt_in [3];
	logic [63:0] cvt_out [3];
	logic [63:0] imm [3];
	logic        has [3];
	imm_out_t    dec;

	// Opcode at a word position, reads past the group see a NOP
	function automatic opcode_e op_at(input ins_group_t grp, input logic [2:0] idx);
		opcode_e op;
		op = OP_NOP;
		if (idx < 3'(`DEC_GROUP_LEN))
			op = grp[idx].any.opcode;
		return op;
	endfunction

	// Postfix opcode for A, B and C in that order
	function automatic opcode_e pfx_op(input int kind);
		case (kind)
		0:       return OP_PFXA32;
		1:       return OP_PFXB32;
		default: return OP_PFXC32;
		endcase
	endfunction

	assign w0 = pop_group[0];
	// Double precision float ops take their postfix constants as singles
	assign fp_dbl = (pop_group[0].any.opcode == OP_FLT3) && (w0[26:25] == 2'd2);

	// ======================================================================
	// Postfix scan
	// ======================================================================
	always_comb
	begin : scan
		logic [2:0] ndx;
		ndx = 3'd1;
		// A vector qualifier sits between the instruction and its postfixes
		if (op_at(pop_group, ndx) == OP_VEC)
			ndx = ndx + 3'd1;
		// Only in-order postfixes are taken, a missing kind is just skipped
		for (int k = 0; k < 3; k++)
		begin
			pfx_lo[k] = 1'b0;
			pfx_hi[k] = 1'b0;
			lo_ndx[k] = 3'd0;
			hi_ndx[k] = 3'd0;
			if (op_at(pop_group, ndx) == pfx_op(k))
			begin
				pfx_lo[k] = 1'b1;
				lo_ndx[k] = ndx;
				ndx = ndx + 3'd1;
				// A repeat of the same kind carries the upper half
				if (op_at(pop_group, ndx) == pfx_op(k))
				begin
					pfx_hi[k] = 1'b1;
					hi_ndx[k] = ndx;
					ndx = ndx + 3'd1;
				end
			end
		end
	end

	// One converter per immediate slot, fed from the first postfix of its kind
	for (genvar k = 0; k < 3; k++)
	begin : g_cvt
		assign cvt_in[k] = pop_group[lo_ndx[k]].pfx.val;
		fp_cvt32to64 u_cvt (.a(cvt_in[k]), .o(cvt_out[k]));
	end

	// ======================================================================
	// Immediate assembly
	// ======================================================================
	always_comb
	begin
		for (int k = 0; k < 3; k++)
		begin
			imm[k] = '0;
			has[k] = 1'b0;
		end
		// Constants embedded in the leading word
		case (pop_group[0].any.opcode)
		OP_ADDI, OP_LDO, OP_STO:
		begin
			imm[1] = {{43{w0[39]}}, pop_group[0].any.imm21};
			has[1] = 1'b1;
		end
		OP_ANDI:
		begin
			// Ones above so the mask keeps the upper bits
			imm[1] = {{43{1'b1}}, pop_group[0].any.imm21};
			has[1] = 1'b1;
		end
		OP_ORI:
		begin
			imm[1] = {51'd0, pop_group[0].any.imm21[12:0]};
			has[1] = 1'b1;
		end
		OP_BCC:
		begin
			// Displacement is split around the condition fields
			imm[2] = {{47{w0[39]}}, w0[39:25], w0[12:11]};
			has[2] = 1'b1;
		end
		default:
		begin
		end
		endcase
		// Postfixes override whatever the leading word supplied
		for (int k = 0; k < 3; k++)
		begin
			if (pfx_lo[k])
			begin
				imm[k] = {{32{cvt_in[k][31]}}, cvt_in[k]};
				if (fp_dbl)
					imm[k] = cvt_out[k];
				if (pfx_hi[k])
					imm[k][63:32] = pop_group[hi_ndx[k]].pfx.val;
				has[k] = 1'b1;
			end
		end
		dec.imma     = imm[0];
		dec.immb     = imm[1];
		dec.immc     = imm[2];
		dec.has_imma = has[0];
		dec.has_immb = has[1];
		dec.has_immc = has[2];
	end

	// ======================================================================
	// Output register
	// ======================================================================
	// Take a group whenever the output slot is free or emptying
	assign pop = pop_valid && (!out_valid || out_ready);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else
			out_valid <= pop || (out_valid && !out_ready);
	end

	always_ff @(posedge clk)
	begin
		if (pop)
			out_imm <= dec;
	end

	// A stalled result stays put until the next stage takes it
	a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_imm));

endmodule

// ==== verilog/fp_cvt32to64.sv ====
// Single to double precision converter
// Purely combinational, denormal inputs flush to signed zero

`timescale 1ns/10ps

module fp_cvt32to64
(
	input  logic [31:0] a,
	output logic [63:0] o
);

	logic        sgn;
	logic [7:0]  exp8;
	logic [22:0] frac;

	assign sgn  = a[31];
	assign exp8 = a[30:23];
	assign frac = a[22:0];

	always_comb
	begin
		if (exp8 == 8'h00)
			// Zero and denormals both give a signed zero
			o = {sgn, 63'd0};
		else if (exp8 == 8'hff)
			// Infinity and NaN keep their fraction bits in the upper positions
			o = {sgn, 11'h7ff, frac, 29'd0};
		else
			// Bias moves from 127 to 1023
			o = {sgn, {3'b000, exp8} + 11'd896, frac, 29'd0};
	end

endmodule

// ==== verilog/ins_group_queue.sv ====
// Instruction group queue
// Circular FIFO of fetch groups, returns one credit per popped entry

`timescale 1ns/10ps
`include "decode_params.svh"

module ins_group_queue import decode_pkg::*;
#(
	parameter int DEPTH = `DEC_QUEUE_DEPTH
)
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       push,
	input  ins_group_t push_group,
	output logic       pop_valid,
	output ins_group_t pop_group,
	input  logic       pop,
	output logic       credit_return
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	ins_group_t       mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Head entry is shown as soon as the write has landed
	assign pop_valid = count != '0;
	assign pop_group = mem[rd_ptr];

	// Storage holds payload only
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_group;
	end

	// ======================================================================
	// Pointers, occupancy and credit return
	// ======================================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end
		else
		begin
			// Pointers wrap by compare so any depth works
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
			endcase
			// The freed entry is reported one cycle after the pop
			credit_return <= pop;
		end
	end

	// The producer's credits keep it from writing into a full queue
	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> count != CNT_W'(DEPTH));

	// The decoder only pops an entry that is on display
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> pop_valid);

endmodule

// ==== verilog/ins_group_former.sv ====
// Instruction group former
// Takes fetch groups under valid/ready and sends them to the group queue,
// spending one credit per push and regaining one per returned credit

`timescale 1ns/10ps
`include "decode_params.svh"

module ins_group_former import decode_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  ins_group_t in_group,
	input  logic       in_valid,
	output logic       in_ready,
	output logic       push,
	output ins_group_t push_group,
	input  logic       credit_return
);

	logic [`DEC_CREDIT_W-1:0] credit_cnt;
	logic                     accept;

	// The send register always drains in the cycle after it fills, so it
	// never blocks a new group by itself
	// A group may only be taken if a credit is left over after the push
	// that is in flight right now
	assign in_ready = credit_cnt > `DEC_CREDIT_W'(push);
	assign accept   = in_valid && in_ready;

	// ======================================================================
	// Send register and credit counter
	// ======================================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			push       <= 1'b0;
			credit_cnt <= `DEC_CREDIT_W'(`DEC_QUEUE_DEPTH);
		end
		else
		begin
			push <= accept;
			// A push and a returned credit in one cycle cancel out
			case ({push, credit_return})
			2'b10:   credit_cnt <= credit_cnt - 1'b1;
			2'b01:   credit_cnt <= credit_cnt + 1'b1;
			default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// Group payload, qualified by push
	always_ff @(posedge clk)
	begin
		if (accept)
			push_group <= in_group;
	end

	// The queue must never hand back more credits than it has entries
	a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		credit_cnt <= `DEC_CREDIT_W'(`DEC_QUEUE_DEPTH));

	// Every push is covered by a credit held at that time
	a_push_credit: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> credit_cnt != '0);

endmodule

// ==== verilog/decode_pkg.sv ====
// Decode pipeline types
// Group payload carried over the credit link and the decoded immediates

`include "decode_params.svh"

package decode_pkg;
	import isa_pkg::*;

	// A fetch group, word 0 is the leading instruction
	typedef instruction_t [`DEC_GROUP_LEN-1:0] ins_group_t;

	// ======================================================================
	// Decoder result
	// ======================================================================
	// Up to three immediates for the leading instruction
	// Each present flag qualifies its immediate
	typedef struct packed {
		logic [63:0] imma;
		logic [63:0] immb;
		logic [63:0] immc;
		logic        has_imma;
		logic        has_immb;
		logic        has_immc;
	} imm_out_t;

endpackage

// ==== verilog/isa_pkg.sv ====
// ISA definitions for the 40-bit variable-length instruction set
// Holds the opcode encoding and the two views of an instruction word

package isa_pkg;

	// ======================================================================
	// Opcodes, always bits 6 to 0 of a word
	// ======================================================================
	typedef enum logic [6:0] {
		OP_NOP    = 7'h00,
		OP_ADDI   = 7'h04,
		OP_ANDI   = 7'h08,
		OP_ORI    = 7'h09,
		OP_LDO    = 7'h43,
		OP_STO    = 7'h53,
		OP_BCC    = 7'h28,
		OP_FLT3   = 7'h63,
		OP_VEC    = 7'h6c,
		OP_PFXA32 = 7'h70,
		OP_PFXB32 = 7'h74,
		OP_PFXC32 = 7'h78
	} opcode_e;

	// General view of a word
	// The upper 21 bits carry the embedded immediate of the immediate forms,
	// the middle field holds register and condition selects that this
	// front end does not decode
	typedef struct packed {
		logic [20:0] imm21;
		logic [10:0] fld;
		logic        rsv;
		opcode_e     opcode;
	} ins_any_t;

	// Postfix view, a 32-bit constant riding above the opcode
	typedef struct packed {
		logic [31:0] val;
		logic        rsv;
		opcode_e     opcode;
	} ins_pfx_t;

	// One 40-bit word, read either way depending on its opcode
	typedef union packed {
		ins_any_t any;
		ins_pfx_t pfx;
	} instruction_t;

endpackage

// ==== verilog/decode_params.svh ====
// Decode front end build parameters
// Sizes shared by the group former, the group queue and the decoder

`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// ======================================================================
// Group geometry
// ======================================================================

// Instruction words delivered per fetch group, word 0 leads
`define DEC_GROUP_LEN 6

// ======================================================================
// Credit link sizing
// ======================================================================

// Default number of entries in the instruction group queue
`define DEC_QUEUE_DEPTH 4

// Wide enough to count the full queue depth of credits
`define DEC_CREDIT_W 3

`endif
